//--- design/qc_code_pkg.sv
package qc_code_pkg;

        //////////////////////////////////////////////////
        // code parameters
        //////////////////////////////////////////////////

        localparam int q = 3;                   // the prime
        localparam int t = 1;                   // correctable errors
        localparam int n = q * q;               // message bits
        localparam int N = 2 * t * q;           // check rows of H
        localparam int K = n + N;               // code bits
        localparam int ec = (q - 1) / 2;        // vote threshold, q is odd

        // counter widths
        localparam int vote_w = $clog2(N + 1);  // holds a count of 0 to N
        localparam int row_idx_w = $clog2(K);   // indexes any of the K rows

        //////////////////////////////////////////////////
        // vector types
        //////////////////////////////////////////////////

        typedef logic [K-1:0] cw_t;             // code word, P_inv row, H row
        typedef logic [N-1:0] syn_t;            // syndrome or one column of H
        typedef logic [n-1:0] msg_t;            // message, S_inv row
        typedef logic [vote_w-1:0] vote_t;      // per-position vote count

endpackage

//--- design/decrypt_fsm_pkg.sv
package decrypt_fsm_pkg;

        // controller phases, in the order they run
        typedef enum logic [3:0] {
                IDLE,
                GET_CIPHER,
                LOAD_H,         // N rows of H
                LOAD_S,         // n rows of S_inv
                LOAD_P,         // K rows of P_inv
                UNPERMUTE,      // c' = P_inv * cipher
                SYNDROME,       // utemp = H * c'
                CORRECT,        // vote and flip
                DESCRAMBLE,     // m = S_inv * m'
                DONE
        } state_e;

        // matrix written by the current load phase
        typedef enum logic [1:0] {KEY_H, KEY_S, KEY_P} key_sel_e;

endpackage

//--- design/key_store.sv
module key_store (
        input  logic                               clk,
        input  logic                               reset,
        input  logic                               wr_en,
        input  decrypt_fsm_pkg::key_sel_e          key_sel,
        input  qc_code_pkg::cw_t                   parity_check_row,
        input  qc_code_pkg::msg_t                  S_inv,
        input  qc_code_pkg::cw_t                   P_inv,
        input  logic [qc_code_pkg::row_idx_w-1:0]  h_idx,
        input  logic [qc_code_pkg::row_idx_w-1:0]  h_col_idx,
        input  logic [qc_code_pkg::row_idx_w-1:0]  s_idx,
        input  logic [qc_code_pkg::row_idx_w-1:0]  p_idx,
        output logic                               load_done,
        output qc_code_pkg::cw_t                   h_row,
        output qc_code_pkg::syn_t                  h_col,
        output qc_code_pkg::msg_t                  s_row,
        output qc_code_pkg::cw_t                   p_row
);

        qc_code_pkg::cw_t  h_mem [qc_code_pkg::N];      // H, row-wise
        qc_code_pkg::msg_t s_mem [qc_code_pkg::n];      // S_inv
        qc_code_pkg::cw_t  p_mem [qc_code_pkg::K];      // P_inv

        logic [qc_code_pkg::row_idx_w-1:0] wr_cnt;      // row being written
        logic [qc_code_pkg::row_idx_w-1:0] last_row;    // final row of selected matrix

        //////////////////////////////////////////////////
        // load counting
        //////////////////////////////////////////////////

        always_comb
        begin
                case (key_sel)
                        decrypt_fsm_pkg::KEY_H: last_row = qc_code_pkg::row_idx_w'(qc_code_pkg::N - 1);
                        decrypt_fsm_pkg::KEY_S: last_row = qc_code_pkg::row_idx_w'(qc_code_pkg::n - 1);
                        default:                last_row = qc_code_pkg::row_idx_w'(qc_code_pkg::K - 1);
                endcase
        end

        assign load_done = wr_en && (wr_cnt == last_row); // same cycle as the last word

        always_ff @(posedge clk)
        begin
                if (reset)
                        wr_cnt <= '0;
                else if (wr_en)
                        wr_cnt <= load_done ? '0 : wr_cnt + 1'b1; // wrap for the next matrix
        end

        // row writes
        always_ff @(posedge clk)
        begin
                if (wr_en)
                begin
                        case (key_sel)
                                decrypt_fsm_pkg::KEY_H: h_mem[wr_cnt[$clog2(qc_code_pkg::N)-1:0]] <= parity_check_row;
                                decrypt_fsm_pkg::KEY_S: s_mem[wr_cnt] <= S_inv;
                                default:                p_mem[wr_cnt] <= P_inv;
                        endcase
                end
        end

        //////////////////////////////////////////////////
        // read ports
        //////////////////////////////////////////////////

        assign h_row = h_mem[h_idx[$clog2(qc_code_pkg::N)-1:0]];
        assign s_row = s_mem[s_idx];
        assign p_row = p_mem[p_idx];

        // column of H gathered from the row store
        always_comb
        begin
                for (int r = 0; r < qc_code_pkg::N; r++)
                        h_col[r] = h_mem[r][h_col_idx];
        end

endmodule

//--- design/gf2_matvec.sv
module gf2_matvec #(
        parameter int ROWS = 15,
        parameter int COLS = 15
) (
        input  logic                               clk,
        input  logic                               reset,
        input  logic                               run,
        input  logic [COLS-1:0]                    vec,
        input  logic [COLS-1:0]                    row,   // matrix row at row_idx
        output logic [qc_code_pkg::row_idx_w-1:0]  row_idx,
        output logic [ROWS-1:0]                    result,
        output logic                               done
);

        logic busy;     // rows 1 onward
        logic active;   // a row is handled this cycle
        logic last;

        assign active = run || busy; // row 0 is handled in the run cycle
        assign last = (row_idx == qc_code_pkg::row_idx_w'(ROWS - 1));

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        busy <= 1'b0;
                        row_idx <= '0;
                        done <= 1'b0;
                end
                else
                begin
                        done <= active && last; // result is complete when done is high
                        if (active)
                        begin
                                busy <= !last;
                                row_idx <= last ? '0 : row_idx + 1'b1;
                        end
                end
        end

        // AND is the GF(2) product, XOR-reduction the sum
        always_ff @(posedge clk)
        begin
                if (active)
                        result[row_idx[$clog2(ROWS)-1:0]] <= ^(row & vec);
        end

endmodule

//--- design/error_corrector.sv
module error_corrector (
        input  logic                               clk,
        input  logic                               reset,
        input  logic                               run,
        input  qc_code_pkg::cw_t                   cdash,
        input  qc_code_pkg::syn_t                  utemp,
        input  qc_code_pkg::syn_t                  h_col,  // column col_idx of H
        output logic [qc_code_pkg::row_idx_w-1:0]  col_idx,
        output qc_code_pkg::msg_t                  mdash,
        output logic                               done
);

        logic busy;
        logic active;
        logic last;
        qc_code_pkg::syn_t hits;        // rows where H and utemp are both set
        qc_code_pkg::vote_t vote;       // integer vote, not GF(2)

        assign active = run || busy;
        assign last = (col_idx == qc_code_pkg::row_idx_w'(qc_code_pkg::n - 1));
        assign hits = h_col & utemp;

        always_comb
        begin
                vote = '0;
                for (int r = 0; r < qc_code_pkg::N; r++)
                        vote = vote + qc_code_pkg::vote_t'(hits[r]);
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        busy <= 1'b0;
                        col_idx <= '0;
                        done <= 1'b0;
                end
                else
                begin
                        done <= active && last;
                        if (active)
                        begin
                                busy <= !last;
                                col_idx <= last ? '0 : col_idx + 1'b1;
                        end
                end
        end

        // flip the bit when more than ec checks point at it
        always_ff @(posedge clk)
        begin
                if (active)
                        mdash[col_idx] <= (vote > qc_code_pkg::vote_t'(qc_code_pkg::ec)) ?
                                          ~cdash[col_idx] : cdash[col_idx];
        end

endmodule

//--- design/decrypt_ctrl.sv
module decrypt_ctrl (
        input  logic                       clk,
        input  logic                       reset,
        input  logic                       start,
        input  logic                       cipher_ready,
        input  qc_code_pkg::cw_t           cipher,
        input  logic                       parity_ready,
        input  logic                       S_inv_ready,
        input  logic                       P_inv_ready,
        input  logic                       load_done,
        input  logic                       unpermute_done,
        input  logic                       syndrome_done,
        input  logic                       correct_done,
        input  logic                       descramble_done,
        input  qc_code_pkg::msg_t          msg_result,
        output logic                       wr_en,
        output decrypt_fsm_pkg::key_sel_e  key_sel,
        output qc_code_pkg::cw_t           cipher_q,
        output logic                       unpermute_run,
        output logic                       syndrome_run,
        output logic                       correct_run,
        output logic                       descramble_run,
        output qc_code_pkg::msg_t          message,
        output logic                       msg_ready
);

        decrypt_fsm_pkg::state_e state;
        logic accept;   // new decryption taken this cycle

        assign accept = (state == decrypt_fsm_pkg::IDLE || state == decrypt_fsm_pkg::DONE) &&
                        start && cipher_ready;

        //////////////////////////////////////////////////
        // load control
        //////////////////////////////////////////////////

        always_comb
        begin
                case (state)
                        decrypt_fsm_pkg::LOAD_S: key_sel = decrypt_fsm_pkg::KEY_S;
                        decrypt_fsm_pkg::LOAD_P: key_sel = decrypt_fsm_pkg::KEY_P;
                        default:                 key_sel = decrypt_fsm_pkg::KEY_H;
                endcase
        end

        // a low ready level just stalls the phase
        assign wr_en = (state == decrypt_fsm_pkg::LOAD_H && parity_ready) ||
                       (state == decrypt_fsm_pkg::LOAD_S && S_inv_ready) ||
                       (state == decrypt_fsm_pkg::LOAD_P && P_inv_ready);

        // each engine starts on the cycle the previous one reports done
        assign syndrome_run = (state == decrypt_fsm_pkg::UNPERMUTE) && unpermute_done;
        assign correct_run = (state == decrypt_fsm_pkg::SYNDROME) && syndrome_done;
        assign descramble_run = (state == decrypt_fsm_pkg::CORRECT) && correct_done;

        always_ff @(posedge clk)
        begin
                if (accept)
                        cipher_q <= cipher;
        end

        //////////////////////////////////////////////////
        // phase FSM
        //////////////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        state <= decrypt_fsm_pkg::IDLE;
                        unpermute_run <= 1'b0;
                        message <= '0;
                        msg_ready <= 1'b0;
                end
                else
                begin
                        unpermute_run <= 1'b0; // single-cycle pulse
                        case (state)
                                decrypt_fsm_pkg::IDLE, decrypt_fsm_pkg::DONE:
                                begin
                                        if (accept)
                                        begin
                                                state <= decrypt_fsm_pkg::GET_CIPHER;
                                                message <= '0;
                                                msg_ready <= 1'b0;
                                        end
                                end
                                decrypt_fsm_pkg::GET_CIPHER: state <= decrypt_fsm_pkg::LOAD_H;
                                decrypt_fsm_pkg::LOAD_H: if (load_done) state <= decrypt_fsm_pkg::LOAD_S;
                                decrypt_fsm_pkg::LOAD_S: if (load_done) state <= decrypt_fsm_pkg::LOAD_P;
                                decrypt_fsm_pkg::LOAD_P:
                                begin
                                        if (load_done)
                                        begin
                                                state <= decrypt_fsm_pkg::UNPERMUTE;
                                                unpermute_run <= 1'b1; // handoff cycle
                                        end
                                end
                                decrypt_fsm_pkg::UNPERMUTE: if (unpermute_done) state <= decrypt_fsm_pkg::SYNDROME;
                                decrypt_fsm_pkg::SYNDROME: if (syndrome_done) state <= decrypt_fsm_pkg::CORRECT;
                                decrypt_fsm_pkg::CORRECT: if (correct_done) state <= decrypt_fsm_pkg::DESCRAMBLE;
                                decrypt_fsm_pkg::DESCRAMBLE:
                                begin
                                        if (descramble_done)
                                        begin
                                                state <= decrypt_fsm_pkg::DONE;
                                                message <= msg_result; // held until next start
                                                msg_ready <= 1'b1;
                                        end
                                end
                                default: state <= decrypt_fsm_pkg::IDLE;
                        endcase
                end
        end

endmodule

//--- design/mceliece_decrypt.sv
module mceliece_decrypt (
        input  logic               clk,
        input  logic               reset,
        input  logic               start,
        input  logic               cipher_ready,
        input  qc_code_pkg::cw_t   cipher,
        input  logic               parity_ready,
        input  qc_code_pkg::cw_t   parity_check_row,
        input  logic               S_inv_ready,
        input  qc_code_pkg::msg_t  S_inv,
        input  logic               P_inv_ready,
        input  qc_code_pkg::cw_t   P_inv,
        output qc_code_pkg::msg_t  message,
        output logic               msg_ready
);

        // control
        logic wr_en;
        logic load_done;
        decrypt_fsm_pkg::key_sel_e key_sel;
        logic unpermute_run, syndrome_run, correct_run, descramble_run;
        logic unpermute_done, syndrome_done, correct_done, descramble_done;

        // key store read indices and rows
        logic [qc_code_pkg::row_idx_w-1:0] p_idx, h_idx, h_col_idx, s_idx;
        qc_code_pkg::cw_t p_row, h_row;
        qc_code_pkg::syn_t h_col;
        qc_code_pkg::msg_t s_row;

        // forward datapath
        qc_code_pkg::cw_t cipher_q, cdash;
        qc_code_pkg::syn_t utemp;
        qc_code_pkg::msg_t mdash, msg_result;

        decrypt_ctrl decrypt_ctrl_inst (
                .clk, .reset, .start, .cipher_ready, .cipher,
                .parity_ready, .S_inv_ready, .P_inv_ready, .load_done,
                .unpermute_done, .syndrome_done, .correct_done, .descramble_done,
                .msg_result, .wr_en, .key_sel, .cipher_q,
                .unpermute_run, .syndrome_run, .correct_run, .descramble_run,
                .message, .msg_ready
        );

        key_store key_store_inst (
                .clk, .reset, .wr_en, .key_sel, .parity_check_row, .S_inv, .P_inv,
                .h_idx, .h_col_idx, .s_idx, .p_idx,
                .load_done, .h_row, .h_col, .s_row, .p_row
        );

        // c' = P_inv * cipher
        gf2_matvec #(.ROWS(qc_code_pkg::K), .COLS(qc_code_pkg::K)) unpermute_inst (
                .clk, .reset, .run(unpermute_run), .vec(cipher_q), .row(p_row),
                .row_idx(p_idx), .result(cdash), .done(unpermute_done)
        );

        // utemp = H * c'
        gf2_matvec #(.ROWS(qc_code_pkg::N), .COLS(qc_code_pkg::K)) syndrome_inst (
                .clk, .reset, .run(syndrome_run), .vec(cdash), .row(h_row),
                .row_idx(h_idx), .result(utemp), .done(syndrome_done)
        );

        error_corrector error_corrector_inst (
                .clk, .reset, .run(correct_run), .cdash, .utemp, .h_col,
                .col_idx(h_col_idx), .mdash, .done(correct_done)
        );

        // m = S_inv * m'
        gf2_matvec #(.ROWS(qc_code_pkg::n), .COLS(qc_code_pkg::n)) descramble_inst (
                .clk, .reset, .run(descramble_run), .vec(mdash), .row(s_row),
                .row_idx(s_idx), .result(msg_result), .done(descramble_done)
        );

endmodule

//--- tb/mceliece_decrypt_assert.sv
module mceliece_decrypt_assert (
        input  logic               clk,
        input  logic               reset,
        input  logic               start,
        input  logic               cipher_ready,
        input  qc_code_pkg::msg_t  message,
        input  logic               msg_ready
);

        timeunit 1ns;
        timeprecision 100ps;

        // no stale result once reset has been seen
        ready_low_after_reset: assert property (@(posedge clk) reset |=> !msg_ready)
                else $error("msg_ready high in the cycle after reset");

        // result held for as long as it is flagged
        message_stable: assert property (@(posedge clk) disable iff (reset)
                $past(msg_ready) && msg_ready |-> message == $past(message))
                else $error("message changed while msg_ready stayed high");

        // only an accepted start clears the result
        ready_falls_on_start: assert property (@(posedge clk) disable iff (reset)
                $fell(msg_ready) |-> $past(start && cipher_ready))
                else $error("msg_ready fell without an accepted start");

endmodule

bind mceliece_decrypt mceliece_decrypt_assert mceliece_decrypt_assert_inst (
        .clk(clk), .reset(reset), .start(start), .cipher_ready(cipher_ready),
        .message(message), .msg_ready(msg_ready)
);

//--- tb/mceliece_decrypt_tb.sv
module mceliece_decrypt_tb;

        timeunit 1ns;
        timeprecision 100ps;

        typedef enum {ZERO_H, ONES_H, RANDOM_KEYS} key_kind_e;

        localparam int num_tests = 9;
        localparam int latency = qc_code_pkg::K + qc_code_pkg::N + 2 * qc_code_pkg::n + 1;
        localparam int load_words = qc_code_pkg::N + qc_code_pkg::n + qc_code_pkg::K;
        localparam int cycle_limit = num_tests * (load_words * 4 + latency + 10);

        logic clk = 1'b0;
        logic reset, start, cipher_ready, parity_ready, S_inv_ready, P_inv_ready;
        qc_code_pkg::cw_t cipher, parity_check_row, P_inv;
        qc_code_pkg::msg_t S_inv, message;
        logic msg_ready;

        int seed = 32'h9fbc;
        int cycle_cnt = 0;

        //////////////////////////////////////////////////
        // test table with model results for the random keys
        //////////////////////////////////////////////////

        string test_name [num_tests] = '{"zero_h_a", "zero_h_b", "ones_h_even", "ones_h_odd",
                "rand_a", "rand_b", "rand_c", "rand_stall_a", "rand_stall_b"};
        qc_code_pkg::cw_t test_cipher [num_tests] = '{15'h5a3c, 15'h7fff, 15'h0003, 15'h4107,
                15'h1234, 15'h6e5d, 15'h0f0f, 15'h2b71, 15'h5555};
        key_kind_e test_kind [num_tests] = '{ZERO_H, ZERO_H, ONES_H, ONES_H,
                RANDOM_KEYS, RANDOM_KEYS, RANDOM_KEYS, RANDOM_KEYS, RANDOM_KEYS};
        bit test_stall [num_tests] = '{0, 0, 0, 0, 0, 0, 0, 1, 1};
        qc_code_pkg::msg_t exp_msg [num_tests] = '{9'h03c, 9'h1ff, 9'h003, 9'h0f8, // odd parity
                9'h000, 9'h000, 9'h000, 9'h000, 9'h000};

        qc_code_pkg::cw_t  h_key [num_tests][qc_code_pkg::N];
        qc_code_pkg::msg_t s_key [num_tests][qc_code_pkg::n];
        qc_code_pkg::cw_t  p_key [num_tests][qc_code_pkg::K];

        mceliece_decrypt mceliece_decrypt_inst (
                .clk, .reset, .start, .cipher_ready, .cipher,
                .parity_ready, .parity_check_row, .S_inv_ready, .S_inv,
                .P_inv_ready, .P_inv, .message, .msg_ready
        );

        always #50 clk = ~clk;  // 100 ns period

        always @(posedge clk)
        begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= cycle_limit)
                begin
                        $display("timeout, no message after %0d cycles", cycle_cnt);
                        abort_run();
                end
        end

        task automatic abort_run();
                $display("test failed");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_message(input string name, input qc_code_pkg::msg_t exp,
                                     input qc_code_pkg::msg_t act);
                if (act !== exp)
                begin
                        $display("** Error %s: message expected %h actual %h", name, exp, act);
                        abort_run();
                end
        endtask

        task automatic check_flag(input string name, input logic exp, input logic act);
                if (act !== exp)
                begin
                        $display("** Error %s: msg_ready expected %b actual %b", name, exp, act);
                        abort_run();
                end
        endtask

        task automatic check_latency(input string name, input int exp, input int act);
                if (act != exp)
                begin
                        $display("** Error %s: latency expected %0d actual %0d", name, exp, act);
                        abort_run();
                end
        endtask

        // software decryption straight from the GF(2) rules
        function automatic qc_code_pkg::msg_t model_message(input qc_code_pkg::cw_t c,
                                                            input int e);
                qc_code_pkg::cw_t cd;
                qc_code_pkg::syn_t ut;
                qc_code_pkg::msg_t md;
                qc_code_pkg::msg_t m;
                int u;
                for (int r = 0; r < qc_code_pkg::K; r++)
                        cd[r] = ^(p_key[e][r] & c);     // undo permutation
                for (int r = 0; r < qc_code_pkg::N; r++)
                        ut[r] = ^(h_key[e][r] & cd);    // syndrome
                for (int i = 0; i < qc_code_pkg::n; i++)
                begin
                        u = 0;
                        for (int r = 0; r < qc_code_pkg::N; r++)
                                if (h_key[e][r][i] && ut[r])
                                        u++;
                        md[i] = (u > qc_code_pkg::ec) ? ~cd[i] : cd[i];
                end
                for (int r = 0; r < qc_code_pkg::n; r++)
                        m[r] = ^(s_key[e][r] & md);     // descramble
                return m;
        endfunction

        task automatic build_keys();
                for (int e = 0; e < num_tests; e++)
                begin
                        for (int r = 0; r < qc_code_pkg::K; r++)
                                if (test_kind[e] == RANDOM_KEYS)
                                        p_key[e][r] = qc_code_pkg::cw_t'($random(seed));
                                else
                                        p_key[e][r] = qc_code_pkg::cw_t'(1) << r;  // identity
                        for (int r = 0; r < qc_code_pkg::n; r++)
                                if (test_kind[e] == RANDOM_KEYS)
                                        s_key[e][r] = qc_code_pkg::msg_t'($random(seed));
                                else
                                        s_key[e][r] = qc_code_pkg::msg_t'(1) << r;
                        for (int r = 0; r < qc_code_pkg::N; r++)
                                case (test_kind[e])
                                        ZERO_H:  h_key[e][r] = '0;
                                        ONES_H:  h_key[e][r] = '1;
                                        default: h_key[e][r] = qc_code_pkg::cw_t'($random(seed));
                                endcase
                        if (test_kind[e] == RANDOM_KEYS)
                                exp_msg[e] = model_message(test_cipher[e], e);
                end
        endtask

        //////////////////////////////////////////////////
        // stimulus
        //////////////////////////////////////////////////

        // runs from a falling edge in the load phase to the one after the last word
        task automatic load_matrix(input decrypt_fsm_pkg::key_sel_e sel, input int e,
                                   input bit stall);
                int rows;
                int w;
                bit go;
                rows = (sel == decrypt_fsm_pkg::KEY_H) ? qc_code_pkg::N :
                       (sel == decrypt_fsm_pkg::KEY_S) ? qc_code_pkg::n : qc_code_pkg::K;
                w = 0;
                while (w < rows)
                begin
                        go = !stall || (($random(seed) & 1) == 0);
                        case (sel)      // junk data while ready is low
                                decrypt_fsm_pkg::KEY_H:
                                begin
                                        parity_ready = go;
                                        parity_check_row = go ? h_key[e][w] : ~h_key[e][w];
                                end
                                decrypt_fsm_pkg::KEY_S:
                                begin
                                        S_inv_ready = go;
                                        S_inv = go ? s_key[e][w] : ~s_key[e][w];
                                end
                                default:
                                begin
                                        P_inv_ready = go;
                                        P_inv = go ? p_key[e][w] : ~p_key[e][w];
                                end
                        endcase
                        @(negedge clk);
                        if (go)
                                w++;
                end
                parity_ready = 1'b0;
                S_inv_ready = 1'b0;
                P_inv_ready = 1'b0;
        endtask

        task automatic run_test(input int e);
                int cap_cycle;
                start = 1'b1;
                cipher_ready = 1'b1;
                cipher = test_cipher[e];
                @(negedge clk);                 // start accepted on this edge
                start = 1'b0;
                cipher_ready = 1'b0;
                cipher = ~test_cipher[e];       // captured copy must hold
                check_flag(test_name[e], 1'b0, msg_ready);
                check_message(test_name[e], '0, message);
                @(negedge clk);
                load_matrix(decrypt_fsm_pkg::KEY_H, e, test_stall[e]);
                load_matrix(decrypt_fsm_pkg::KEY_S, e, test_stall[e]);
                load_matrix(decrypt_fsm_pkg::KEY_P, e, test_stall[e]);
                cap_cycle = cycle_cnt;          // edge of the last P_inv word
                while (msg_ready !== 1'b1)
                        @(negedge clk);         // wait for the result
                check_latency(test_name[e], latency, cycle_cnt - cap_cycle);
                check_message(test_name[e], exp_msg[e], message);
                for (int i = 0; i < 3; i++)
                begin
                        start = (i == 1);       // start alone is not accepted
                        @(negedge clk);
                        check_flag(test_name[e], 1'b1, msg_ready);
                        check_message(test_name[e], exp_msg[e], message);
                end
                start = 1'b0;
        endtask

        initial
        begin
                reset = 1'b1;
                start = 1'b0;
                cipher_ready = 1'b0;
                cipher = '0;
                parity_ready = 1'b0;
                parity_check_row = '0;
                S_inv_ready = 1'b0;
                S_inv = '0;
                P_inv_ready = 1'b0;
                P_inv = '0;
                build_keys();
                repeat (3) @(negedge clk);
                reset = 1'b0;
                check_flag("after_reset", 1'b0, msg_ready);
                check_message("after_reset", '0, message);
                for (int e = 0; e < num_tests; e++)
                        run_test(e);
                $display("test passed");
                $finish;
        end

endmodule

//--- mceliece_decrypt.f
design/qc_code_pkg.sv
design/decrypt_fsm_pkg.sv
design/key_store.sv
design/gf2_matvec.sv
design/error_corrector.sv
design/decrypt_ctrl.sv
design/mceliece_decrypt.sv
tb/mceliece_decrypt_assert.sv
tb/mceliece_decrypt_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
        --top-module mceliece_decrypt_tb -f mceliece_decrypt.f
./obj_dir/Vmceliece_decrypt_tb > sim.log 2>&1 || echo "test failed" >> sim.log
cat sim.log
if grep -q "test failed" sim.log; then
        exit 1
fi
grep -q "test passed" sim.log
exit 0
